/* i2c_target_standby.f */
src/i2c_standby_pkg.sv
src/tti_port_if.sv
src/sync_fifo.sv
src/bus_event_decoder.sv
src/standby_flow_fsm.sv
src/tti_queues.sv
src/i2c_target_standby.sv
dv/tb_clock_gen.sv
dv/tb_i2c_target_standby.sv

/* Makefile */
# Verilator build and run for the I2C target standby bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_i2c_target_standby
FILELIST  ?= i2c_target_standby.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
RUN_ARGS  ?=

SOURCES := $(wildcard src/*.sv dv/*.sv)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# A failed check ends in $fatal, which gives a nonzero exit status
run: compile
	./$(BINARY) $(RUN_ARGS)

clean:
	rm -rf $(BUILD_DIR)

/* dv/tb_i2c_target_standby.sv */
// Directed testbench for the I2C target standby bridge, run through the Verilator Makefile
`timescale 1ns/1ps

module tb_i2c_target_standby
  import i2c_standby_pkg::*;
();

  localparam int WaitCycles = 50;

  typedef enum logic [1:0] {
    WaitReset,
    WaitRxData,
    WaitResp
  } wait_sel_e;

  logic        clk;
  logic        rst_n;
  logic        bus_evt_valid_i;
  bus_evt_e    bus_evt_id_i;
  logic [7:0]  bus_evt_data_i;
  logic        rd_byte_valid_o;
  logic [7:0]  rd_byte_o;
  logic        err_o;
  logic        cmd_push_i;
  logic [15:0] cmd_len_i;
  logic        tx_push_i;
  logic [7:0]  tx_data_i;
  logic        rx_pop_i;
  logic        resp_pop_i;
  logic [7:0]  rx_data_o;
  logic        rx_empty_o;
  logic [15:0] resp_len_o;
  resp_err_e   resp_err_o;
  logic        resp_empty_o;
  int          seed;
  int          err_pulses = 0;
  int          err_base = 0;

  tb_clock_gen i_tb_clock_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  i2c_target_standby i_i2c_target_standby (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .bus_evt_valid_i (bus_evt_valid_i),
    .bus_evt_id_i    (bus_evt_id_i),
    .bus_evt_data_i  (bus_evt_data_i),
    .rd_byte_valid_o (rd_byte_valid_o),
    .rd_byte_o       (rd_byte_o),
    .err_o           (err_o),
    .cmd_push_i      (cmd_push_i),
    .cmd_len_i       (cmd_len_i),
    .tx_push_i       (tx_push_i),
    .tx_data_i       (tx_data_i),
    .rx_pop_i        (rx_pop_i),
    .resp_pop_i      (resp_pop_i),
    .rx_data_o       (rx_data_o),
    .rx_empty_o      (rx_empty_o),
    .resp_len_o      (resp_len_o),
    .resp_err_o      (resp_err_o),
    .resp_empty_o    (resp_empty_o)
  );

  // Counts err_o pulses, sampled away from the active edge
  always @(negedge clk) begin
    if (err_o === 1'b1) begin
      err_pulses <= err_pulses + 1;
    end
  end

  task automatic fail_now(input string reason);
    $display("%s", reason);
    $display("Test failures found");
    $fatal(1, "simulation stopped on the first failure");
  endtask

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      fail_now($sformatf("error at %0t ns: %s, got 0x%0h, expected 0x%0h",
                         $time, what, got, exp));
    end
  endtask

  function automatic bit cond_met(input wait_sel_e sel);
    case (sel)
      WaitReset:  return rst_n == 1'b1;
      WaitRxData: return rx_empty_o == 1'b0;
      WaitResp:   return resp_empty_o == 1'b0;
      default:    return 1'b0;
    endcase
  endfunction

  task automatic wait_for(input wait_sel_e sel, input string what);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!cond_met(sel) && cycles < WaitCycles) begin
      @(negedge clk);
      cycles++;
    end
    if (!cond_met(sel)) begin
      fail_now($sformatf("timeout: %s did not happen within %0d cycles", what, WaitCycles));
    end
  endtask

  task automatic send_event(input bus_evt_e id, input logic [7:0] data);
    @(posedge clk);
    bus_evt_valid_i <= 1'b1;
    bus_evt_id_i    <= id;
    bus_evt_data_i  <= data;
    @(posedge clk);
    bus_evt_valid_i <= 1'b0;
  endtask

  task automatic push_cmd(input logic [15:0] len);
    @(posedge clk);
    cmd_push_i <= 1'b1;
    cmd_len_i  <= len;
    @(posedge clk);
    cmd_push_i <= 1'b0;
  endtask

  task automatic push_tx(input logic [7:0] data);
    @(posedge clk);
    tx_push_i <= 1'b1;
    tx_data_i <= data;
    @(posedge clk);
    tx_push_i <= 1'b0;
  endtask

  // The answer must appear exactly two cycles after the request strobe
  task automatic read_request(input logic [7:0] exp_byte);
    send_event(EvtReadReq, 8'h00);
    @(negedge clk);
    check_eq(32'(rd_byte_valid_o), 32'd0, "rd_byte_valid_o one cycle after read request");
    @(negedge clk);
    check_eq(32'(rd_byte_valid_o), 32'd1, "rd_byte_valid_o two cycles after read request");
    check_eq(32'(rd_byte_o), 32'(exp_byte), "rd_byte_o");
  endtask

  task automatic pop_rx_check(input logic [7:0] exp_byte);
    wait_for(WaitRxData, "RX byte available");
    check_eq(32'(rx_data_o), 32'(exp_byte), "rx_data_o");
    @(posedge clk);
    rx_pop_i <= 1'b1;
    @(posedge clk);
    rx_pop_i <= 1'b0;
  endtask

  task automatic check_resp(input logic [15:0] len, input resp_err_e err, input string what);
    wait_for(WaitResp, what);
    check_eq(32'(resp_len_o), 32'(len), {what, " length"});
    check_eq(32'(resp_err_o), 32'(err), {what, " status"});
    @(posedge clk);
    resp_pop_i <= 1'b1;
    @(posedge clk);
    resp_pop_i <= 1'b0;
  endtask

  task automatic expect_errs(input int n, input string what);
    @(posedge clk);
    check_eq(32'(err_pulses - err_base), 32'(n), what);
    err_base = err_pulses;
  endtask

  task automatic test_write_xfer();
    logic [7:0] exp_q [$];
    logic [7:0] b;
    send_event(EvtStartWrite, 8'h00);
    repeat (5) begin
      b = 8'($random(seed));
      exp_q.push_back(b);
      send_event(EvtData, b);
    end
    send_event(EvtStop, 8'h00);
    while (exp_q.size() > 0) begin
      pop_rx_check(exp_q.pop_front());
    end
    check_resp(16'd5, RespOk, "write response");
    expect_errs(0, "err_o pulses in write transfer");
  endtask

  task automatic test_read_xfer();
    logic [7:0] exp_q [$];
    logic [7:0] b;
    push_cmd(16'd3);
    repeat (3) begin
      b = 8'($random(seed));
      exp_q.push_back(b);
      push_tx(b);
    end
    send_event(EvtStartRead, 8'h00);
    while (exp_q.size() > 0) begin
      read_request(exp_q.pop_front());
    end
    send_event(EvtStop, 8'h00);
    check_resp(16'd3, RespOk, "read response");
    expect_errs(0, "err_o pulses in read transfer");
  endtask

  task automatic test_restart();
    logic [7:0] w0;
    logic [7:0] w1;
    logic [7:0] r0;
    w0 = 8'($random(seed));
    w1 = 8'($random(seed));
    r0 = 8'($random(seed));
    push_cmd(16'd1);
    push_tx(r0);
    send_event(EvtStartWrite, 8'h00);
    send_event(EvtData, w0);
    send_event(EvtData, w1);
    send_event(EvtRestart, 8'h00);
    send_event(EvtStartRead, 8'h00);
    read_request(r0);
    send_event(EvtStop, 8'h00);
    pop_rx_check(w0);
    pop_rx_check(w1);
    check_resp(16'd2, RespOk, "response closed by restart");
    check_resp(16'd1, RespOk, "response closed by stop");
    expect_errs(0, "err_o pulses around restart");
  endtask

  task automatic test_read_underflow();
    logic [7:0] b;
    b = 8'($random(seed));
    push_cmd(16'd2);
    push_tx(b);
    send_event(EvtStartRead, 8'h00);
    read_request(b);
    // TX queue is empty now
    send_event(EvtReadReq, 8'h00);
    send_event(EvtStop, 8'h00);
    check_resp(16'd1, RespUnderflow, "underflow response");
    expect_errs(1, "err_o pulses on read underflow");
  endtask

  task automatic test_write_overflow();
    logic [7:0] exp_q [$];
    logic [7:0] b;
    send_event(EvtStartWrite, 8'h00);
    repeat (RxDepth + 1) begin
      b = 8'($random(seed));
      if (exp_q.size() < RxDepth) begin
        exp_q.push_back(b);
      end
      send_event(EvtData, b);
    end
    send_event(EvtStop, 8'h00);
    while (exp_q.size() > 0) begin
      pop_rx_check(exp_q.pop_front());
    end
    @(negedge clk);
    check_eq(32'(rx_empty_o), 32'd1, "rx_empty_o after draining RX queue");
    check_resp(16'(RxDepth), RespOverflow, "overflow response");
    expect_errs(1, "err_o pulses on write overflow");
  endtask

  task automatic test_protocol_errors();
    // Data byte inside a read transfer
    push_cmd(16'd1);
    send_event(EvtStartRead, 8'h00);
    send_event(EvtData, 8'ha5);
    send_event(EvtStop, 8'h00);
    check_resp(16'd0, RespProtocol, "data during read response");
    expect_errs(1, "err_o pulses on data during read");
    // Read start with an empty command queue
    send_event(EvtStartRead, 8'h00);
    send_event(EvtStop, 8'h00);
    check_resp(16'd0, RespProtocol, "missing command response");
    expect_errs(1, "err_o pulses on missing command");
    // Code 7 has no event behind it
    send_event(bus_evt_e'(3'd7), 8'h00);
    send_event(EvtStop, 8'h00);
    check_resp(16'd0, RespProtocol, "unknown event response");
    expect_errs(1, "err_o pulses on unknown event");
  endtask

  initial begin
    seed            = 64265;
    bus_evt_valid_i = 1'b0;
    bus_evt_id_i    = EvtStop;
    bus_evt_data_i  = 8'h00;
    cmd_push_i      = 1'b0;
    cmd_len_i       = 16'h0000;
    tx_push_i       = 1'b0;
    tx_data_i       = 8'h00;
    rx_pop_i        = 1'b0;
    resp_pop_i      = 1'b0;
    wait_for(WaitReset, "reset release");
    test_write_xfer();
    test_read_xfer();
    test_restart();
    test_read_underflow();
    test_write_overflow();
    test_protocol_errors();
    $display("All tests passed!");
    $finish;
  end

endmodule

/* dv/tb_clock_gen.sv */
// Testbench clock and reset source, 4 ns clock with reset held low for the first 5 cycles
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam int ResetCycles = 5;

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_no <= 1'b1;
  end

  // Half period of 2 ns
  always #2 clk_o = ~clk_o;

endmodule

/* src/i2c_target_standby.sv */
// Top level of the I2C target standby bridge, connects decoder, flow FSM and queues
`timescale 1ns/1ps

module i2c_target_standby
  import i2c_standby_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,

  // Bus-side events and read answers
  input  logic        bus_evt_valid_i,
  input  bus_evt_e    bus_evt_id_i,
  input  logic [7:0]  bus_evt_data_i,
  output logic        rd_byte_valid_o,
  output logic [7:0]  rd_byte_o,
  output logic        err_o,

  // Host-side queue access
  input  logic        cmd_push_i,
  input  logic [15:0] cmd_len_i,
  input  logic        tx_push_i,
  input  logic [7:0]  tx_data_i,
  input  logic        rx_pop_i,
  input  logic        resp_pop_i,
  output logic [7:0]  rx_data_o,
  output logic        rx_empty_o,
  output logic [15:0] resp_len_o,
  output resp_err_e   resp_err_o,
  output logic        resp_empty_o
);

  logic                     evt_valid;
  logic [EvtFlagsWidth-1:0] evt_flags;
  logic [7:0]               evt_data;

  tti_port_if tti ();

  bus_evt_decoder i_bus_evt_decoder (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .evt_valid_i (bus_evt_valid_i),
    .evt_id_i    (bus_evt_id_i),
    .evt_data_i  (bus_evt_data_i),
    .evt_valid_o (evt_valid),
    .evt_flags_o (evt_flags),
    .evt_data_o  (evt_data)
  );

  standby_flow_fsm i_standby_flow_fsm (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .evt_valid_i     (evt_valid),
    .evt_flags_i     (evt_flags),
    .evt_data_i      (evt_data),
    .tti             (tti),
    .rd_byte_valid_o (rd_byte_valid_o),
    .rd_byte_o       (rd_byte_o),
    .err_o           (err_o)
  );

  tti_queues i_tti_queues (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cmd_push_i   (cmd_push_i),
    .cmd_len_i    (cmd_len_i),
    .tx_push_i    (tx_push_i),
    .tx_data_i    (tx_data_i),
    .rx_pop_i     (rx_pop_i),
    .resp_pop_i   (resp_pop_i),
    .rx_data_o    (rx_data_o),
    .rx_empty_o   (rx_empty_o),
    .resp_len_o   (resp_len_o),
    .resp_err_o   (resp_err_o),
    .resp_empty_o (resp_empty_o),
    .tti          (tti)
  );

endmodule

/* src/tti_queues.sv */
// Host-facing queue block of the bridge, holds the command, TX, RX and response FIFOs
`timescale 1ns/1ps

module tti_queues
  import i2c_standby_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        cmd_push_i,
  input  logic [15:0] cmd_len_i,
  input  logic        tx_push_i,
  input  logic [7:0]  tx_data_i,
  input  logic        rx_pop_i,
  input  logic        resp_pop_i,
  output logic [7:0]  rx_data_o,
  output logic        rx_empty_o,
  output logic [15:0] resp_len_o,
  output resp_err_e   resp_err_o,
  output logic        resp_empty_o,
  tti_port_if.queues  tti
);

  cmd_desc_t             cmd_wdata;
  logic [CmdWidth-1:0]   cmd_rdata;
  logic [RespWidth-1:0]  resp_rdata;
  resp_desc_t            resp_head;
  logic                  cmd_empty;
  logic                  tx_empty;
  logic                  rx_full_raw;
  logic [RxCntWidth-1:0] rx_level_q;
  logic                  rx_wr;
  logic                  rx_rd;

  assign cmd_wdata.data_length = cmd_len_i;

  sync_fifo #(.Depth(CmdDepth), .Width(CmdWidth)) i_cmd_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (cmd_push_i),
    .wdata_i (cmd_wdata),
    .pop_i   (tti.cmd_pop),
    .rdata_o (cmd_rdata),
    .empty_o (cmd_empty),
    .full_o  ()
  );

  sync_fifo #(.Depth(TxDepth), .Width(8)) i_tx_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (tx_push_i),
    .wdata_i (tx_data_i),
    .pop_i   (tti.tx_pop),
    .rdata_o (tti.tx_byte),
    .empty_o (tx_empty),
    .full_o  ()
  );

  sync_fifo #(.Depth(RxDepth), .Width(8)) i_rx_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (tti.rx_push),
    .wdata_i (tti.rx_byte),
    .pop_i   (rx_pop_i),
    .rdata_o (rx_data_o),
    .empty_o (rx_empty_o),
    .full_o  (rx_full_raw)
  );

  sync_fifo #(.Depth(RespDepth), .Width(RespWidth)) i_resp_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (tti.resp_push),
    .wdata_i (tti.resp_desc),
    .pop_i   (resp_pop_i),
    .rdata_o (resp_rdata),
    .empty_o (resp_empty_o),
    .full_o  ()
  );

  assign tti.cmd_desc  = cmd_desc_t'(cmd_rdata);
  assign tti.cmd_valid = ~cmd_empty;
  assign tti.tx_valid  = ~tx_empty;

  assign resp_head  = resp_desc_t'(resp_rdata);
  assign resp_len_o = resp_head.data_length;
  assign resp_err_o = resp_head.err_status;

  // RX level tracked here so the FSM also sees the push still in flight
  assign rx_wr = tti.rx_push & ~rx_full_raw;
  assign rx_rd = rx_pop_i & ~rx_empty_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rx_level_q <= '0;
    end else if (rx_wr && !rx_rd) begin
      rx_level_q <= rx_level_q + 1'b1;
    end else if (rx_rd && !rx_wr) begin
      rx_level_q <= rx_level_q - 1'b1;
    end
  end

  assign tti.rx_full = rx_full_raw |
                       (tti.rx_push & ~rx_rd & (rx_level_q == RxCntWidth'(RxDepth - 1)));

endmodule

/* src/standby_flow_fsm.sv */
// Transfer FSM of the bridge, moves bytes between bus events and queues and builds responses
`timescale 1ns/1ps

module standby_flow_fsm
  import i2c_standby_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     evt_valid_i,
  input  logic [EvtFlagsWidth-1:0] evt_flags_i,
  input  logic [7:0]               evt_data_i,
  tti_port_if.fsm                  tti,
  output logic                     rd_byte_valid_o,
  output logic [7:0]               rd_byte_o,
  output logic                     err_o
);

  typedef enum logic [2:0] {
    Idle      = 3'd0,
    WriteXfer = 3'd1,
    ReadXfer  = 3'd2,
    ReadDone  = 3'd3,
    Error     = 3'd4
  } state_e;

  state_e      state_q;
  state_e      state_d;
  logic [15:0] byte_cnt_q;
  logic [15:0] byte_cnt_d;
  logic [15:0] rd_len_q;
  logic [15:0] rd_len_d;
  resp_err_e   err_code_q;
  resp_err_e   err_code_d;
  resp_err_e   raise_code;
  logic        raise_err;
  logic        push_rx;
  logic        push_resp;
  logic        send_byte;

  logic ev_start_wr;
  logic ev_start_rd;
  logic ev_end;
  logic ev_data;
  logic ev_nack;
  logic ev_rd_req;
  logic ev_illegal;

  assign ev_start_wr = evt_valid_i & evt_flags_i[EvtStartWrite];
  assign ev_start_rd = evt_valid_i & evt_flags_i[EvtStartRead];
  // Stop and restart both close the current transfer
  assign ev_end      = evt_valid_i & (evt_flags_i[EvtStop] | evt_flags_i[EvtRestart]);
  assign ev_data     = evt_valid_i & evt_flags_i[EvtData];
  assign ev_nack     = evt_valid_i & evt_flags_i[EvtNack];
  assign ev_rd_req   = evt_valid_i & evt_flags_i[EvtReadReq];
  assign ev_illegal  = evt_valid_i & evt_flags_i[FlagIllegal];

  always_comb begin
    state_d     = state_q;
    byte_cnt_d  = byte_cnt_q;
    rd_len_d    = rd_len_q;
    err_code_d  = err_code_q;
    raise_err   = 1'b0;
    raise_code  = RespProtocol;
    push_rx     = 1'b0;
    push_resp   = 1'b0;
    send_byte   = 1'b0;
    tti.cmd_pop = 1'b0;
    tti.tx_pop  = 1'b0;

    if (ev_illegal && state_q != Error) begin
      raise_err = 1'b1;
    end else if (ev_end && state_q != Idle) begin
      push_resp = 1'b1;
    end else begin
      case (state_q)
        Idle: begin
          if (ev_start_wr) begin
            state_d = WriteXfer;
          end else if (ev_start_rd) begin
            if (!tti.cmd_valid) begin
              raise_err = 1'b1;
            end else begin
              // A zero-length command is consumed too, it would block the queue
              tti.cmd_pop = 1'b1;
              rd_len_d    = tti.cmd_desc.data_length;
              if (tti.cmd_desc.data_length == '0) begin
                raise_err = 1'b1;
              end else begin
                state_d = ReadXfer;
              end
            end
          end else if (ev_data || ev_nack || ev_rd_req) begin
            raise_err = 1'b1;
          end
        end
        WriteXfer: begin
          if (ev_data) begin
            if (tti.rx_full) begin
              raise_err  = 1'b1;
              raise_code = RespOverflow;
            end else begin
              push_rx    = 1'b1;
              byte_cnt_d = byte_cnt_q + 16'd1;
            end
          end else if (ev_start_wr || ev_start_rd || ev_rd_req) begin
            raise_err = 1'b1;
          end
        end
        ReadXfer: begin
          if (ev_rd_req) begin
            if (!tti.tx_valid) begin
              raise_err  = 1'b1;
              raise_code = RespUnderflow;
            end else begin
              tti.tx_pop = 1'b1;
              send_byte  = 1'b1;
              byte_cnt_d = byte_cnt_q + 16'd1;
              if (byte_cnt_q + 16'd1 == rd_len_q) begin
                state_d = ReadDone;
              end
            end
          end else if (ev_nack || ev_data || ev_start_wr || ev_start_rd) begin
            // NACK here means the controller gave up before the read length
            raise_err = 1'b1;
          end
        end
        ReadDone: begin
          // Closing NACK is expected, more read requests are not
          if (ev_rd_req || ev_data || ev_start_wr || ev_start_rd) begin
            raise_err = 1'b1;
          end
        end
        Error: begin
          // Events are dropped until stop or restart
        end
        default: state_d = Idle;
      endcase
    end

    if (push_resp) begin
      state_d    = Idle;
      byte_cnt_d = '0;
      err_code_d = RespOk;
    end
    if (raise_err) begin
      state_d    = Error;
      err_code_d = raise_code;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q         <= Idle;
      byte_cnt_q      <= '0;
      rd_len_q        <= '0;
      err_code_q      <= RespOk;
      err_o           <= 1'b0;
      rd_byte_valid_o <= 1'b0;
      tti.rx_push     <= 1'b0;
      tti.resp_push   <= 1'b0;
    end else begin
      state_q         <= state_d;
      byte_cnt_q      <= byte_cnt_d;
      rd_len_q        <= rd_len_d;
      err_code_q      <= err_code_d;
      err_o           <= raise_err;
      rd_byte_valid_o <= send_byte;
      tti.rx_push     <= push_rx;
      tti.resp_push   <= push_resp;
    end
  end

  // Response takes the count and status as they stand before the closing event
  always_ff @(posedge clk_i) begin
    if (send_byte) begin
      rd_byte_o <= tti.tx_byte;
    end
    if (push_rx) begin
      tti.rx_byte <= evt_data_i;
    end
    if (push_resp) begin
      tti.resp_desc <= '{err_status: err_code_q, data_length: byte_cnt_q};
    end
  end

  a_state_legal: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    state_q inside {Idle, WriteXfer, ReadXfer, ReadDone, Error}
  );

  a_cmd_pop_valid: assert property (
    @(posedge clk_i) disable iff (!rst_ni) tti.cmd_pop |-> tti.cmd_valid
  );

  a_tx_pop_valid: assert property (
    @(posedge clk_i) disable iff (!rst_ni) tti.tx_pop |-> tti.tx_valid
  );

endmodule

/* src/bus_event_decoder.sv */
// Input stage of the bridge, registers each bus event and decodes its identifier into flags
`timescale 1ns/1ps

module bus_evt_decoder
  import i2c_standby_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     evt_valid_i,
  input  bus_evt_e                 evt_id_i,
  input  logic [7:0]               evt_data_i,
  output logic                     evt_valid_o,
  output logic [EvtFlagsWidth-1:0] evt_flags_o,
  output logic [7:0]               evt_data_o
);

  logic [EvtFlagsWidth-1:0] flags_d;

  // Flag position equals the event code, anything unlisted is illegal
  always_comb begin
    flags_d = '0;
    if (evt_id_i inside {EvtStartWrite, EvtStartRead, EvtRestart, EvtStop,
                         EvtData, EvtNack, EvtReadReq}) begin
      flags_d[evt_id_i] = 1'b1;
    end else begin
      flags_d[FlagIllegal] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      evt_valid_o <= 1'b0;
      evt_flags_o <= '0;
    end else begin
      evt_valid_o <= evt_valid_i;
      if (evt_valid_i) begin
        evt_flags_o <= flags_d;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (evt_valid_i) begin
      evt_data_o <= evt_data_i;
    end
  end

  a_flags_onehot: assert property (
    @(posedge clk_i) disable iff (!rst_ni) evt_valid_o |-> $onehot(evt_flags_o)
  );

endmodule

/* src/sync_fifo.sv */
// Show-ahead synchronous FIFO with occupancy count, instantiated for every bridge queue
`timescale 1ns/1ps

module sync_fifo #(
  parameter int Depth = 4,
  parameter int Width = 8
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             push_i,
  input  logic [Width-1:0] wdata_i,
  input  logic             pop_i,
  output logic [Width-1:0] rdata_o,
  output logic             empty_o,
  output logic             full_o
);

  localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntWidth = $clog2(Depth + 1);

  logic [Width-1:0]    mem_q [Depth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                do_push;
  logic                do_pop;

  // Overflowing pushes and underflowing pops are dropped
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

  // Head is valid whenever the FIFO is not empty
  assign rdata_o = mem_q[rd_ptr_q];
  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CntWidth'(Depth));

  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_o);
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni) pop_i |-> !empty_o);

endmodule

/* src/tti_port_if.sv */
// Queue-side bundle between the flow FSM and the transfer queues, one modport per side
`timescale 1ns/1ps

interface tti_port_if
  import i2c_standby_pkg::*;
();

  // Pops and pushes are single-cycle strobes
  logic       cmd_valid;
  logic       cmd_pop;
  cmd_desc_t  cmd_desc;
  logic       tx_valid;
  logic       tx_pop;
  logic [7:0] tx_byte;
  logic       rx_push;
  logic [7:0] rx_byte;
  logic       rx_full;
  logic       resp_push;
  resp_desc_t resp_desc;

  modport fsm (
    input  cmd_valid, cmd_desc, tx_valid, tx_byte, rx_full,
    output cmd_pop, tx_pop, rx_push, rx_byte, resp_push, resp_desc
  );

  modport queues (
    input  cmd_pop, tx_pop, rx_push, rx_byte, resp_push, resp_desc,
    output cmd_valid, cmd_desc, tx_valid, tx_byte, rx_full
  );

endinterface

/* src/i2c_standby_pkg.sv */
// Event codes, descriptor layouts and queue sizes shared by every block of the standby bridge
package i2c_standby_pkg;

  // Bus-side event identifiers, code 7 is unused and decodes as illegal
  typedef enum logic [2:0] {
    EvtStartWrite = 3'd0,
    EvtStartRead  = 3'd1,
    EvtRestart    = 3'd2,
    EvtStop       = 3'd3,
    EvtData       = 3'd4,
    EvtNack       = 3'd5,
    EvtReadReq    = 3'd6
  } bus_evt_e;

  // One flag per event code, the top flag marks an unknown code
  localparam int EvtFlagsWidth = 8;
  localparam int FlagIllegal   = 7;

  // Status reported back to the host with each response
  typedef enum logic [1:0] {
    RespOk        = 2'd0,
    RespOverflow  = 2'd1,
    RespUnderflow = 2'd2,
    RespProtocol  = 2'd3
  } resp_err_e;

  // Host command, number of bytes the next read returns
  typedef struct packed {
    logic [15:0] data_length;
  } cmd_desc_t;

  // Response written at the end of every transfer
  typedef struct packed {
    resp_err_e   err_status;
    logic [15:0] data_length;
  } resp_desc_t;

  // Queue depths in entries
  localparam int CmdDepth  = 4;
  localparam int TxDepth   = 16;
  localparam int RxDepth   = 16;
  localparam int RespDepth = 4;

  localparam int CmdWidth  = $bits(cmd_desc_t);
  localparam int RespWidth = $bits(resp_desc_t);

  // Width of the RX occupancy count, 0 up to RxDepth
  localparam int RxCntWidth = $clog2(RxDepth + 1);

endpackage
